//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - design
    files:
      - design/mips_pkg.sv
      - design/mips_regfile.sv
      - design/mips_decode.sv
      - design/mips_alu.sv
      - design/mips_hazard.sv
      - design/mips_dmem.sv
      - design/mips_core.sv
  - target: test
    include_dirs:
      - design
      - dv
    files:
      - dv/mips_tb.sv

//--- design/mips_alu.sv
`default_nettype none

`include "mips_defines.svh"

module mips_alu (
	input  mips_pkg::alu_op_e      op,
	input  wire [`MIPS_XLEN-1:0]   a,
	input  wire [`MIPS_XLEN-1:0]   b,
	output logic [`MIPS_XLEN-1:0]  result
);

	localparam int MSB = `MIPS_XLEN-1;

	logic [`MIPS_XLEN-1:0] sum;
	logic [`MIPS_XLEN-1:0] diff;
	logic                  sub_ovf;
	logic                  less;

	assign sum  = a + b;
	assign diff = a - b;

	// subtract overflows when the signs differ and the result
	// takes the sign of b
	assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	// true sign of a-b, flipped back when it overflowed
	assign less = diff[MSB] ^ sub_ovf;

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD: result = sum;
			mips_pkg::ALU_SUB: result = diff;
			mips_pkg::ALU_AND: result = a & b;
			mips_pkg::ALU_OR:  result = a | b;
			mips_pkg::ALU_XOR: result = a ^ b;
			mips_pkg::ALU_NOR: result = ~(a | b);
			mips_pkg::ALU_SLT: result = {{MSB{1'b0}}, less};
			default:           result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/mips_core.sv
`default_nettype none

`include "mips_defines.svh"

module mips_core (
	input  wire                   clk,
	input  wire                   reset,
	output logic [`MIPS_XLEN-1:0] imem_addr,  // byte address
	input  wire [`MIPS_XLEN-1:0]  imem_data,
	output mips_pkg::wb_t         wb,
	output mips_pkg::store_t      store
);

	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] if_id_instr;  // fetch/decode register

	mips_pkg::id_ex_t  id_ctrl;   // decode output, before operands
	mips_pkg::id_ex_t  id_ex_d;
	mips_pkg::id_ex_t  id_ex;
	mips_pkg::ex_mem_t ex_mem_d;
	mips_pkg::ex_mem_t ex_mem;
	mips_pkg::mem_wb_t mem_wb;

	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;
	logic [`MIPS_XLEN-1:0] op_a;
	logic [`MIPS_XLEN-1:0] op_b_reg;  // forwarded rt, before immediate select
	logic [`MIPS_XLEN-1:0] alu_b;
	logic [`MIPS_XLEN-1:0] alu_result;
	logic [`MIPS_XLEN-1:0] mem_rdata;
	logic [`MIPS_XLEN-1:0] wb_data;

	mips_pkg::fwd_sel_e fwd_a;
	mips_pkg::fwd_sel_e fwd_b;
	logic               stall;

	// fetch
	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (!stall)
			pc <= pc + `MIPS_PC_STEP;
	end

	always_ff @(posedge clk) begin
		if (reset)
			if_id_instr <= '0; // all zero word is a nop
		else if (!stall)
			if_id_instr <= imem_data;
	end

	// decode
	mips_decode u_decode (
		.instr (if_id_instr),
		.ctrl  (id_ctrl)
	);

	mips_regfile u_regfile (
		.clk     (clk),
		.rs_idx  (id_ctrl.rs),
		.rt_idx  (id_ctrl.rt),
		.wr      (wb),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	always_comb begin
		id_ex_d         = id_ctrl;
		id_ex_d.rs_data = rs_data;
		id_ex_d.rt_data = rt_data;
	end

	// a stall turns the slot behind the load into a bubble
	always_ff @(posedge clk) begin
		if (reset || stall)
			id_ex <= '0;
		else
			id_ex <= id_ex_d;
	end

	mips_hazard u_hazard (
		.id_rs    (id_ctrl.rs),
		.id_rt    (id_ctrl.rt),
		.ex       (id_ex),
		.mem      (ex_mem),
		.wb_dest  (mem_wb.dest),
		.wb_write (mem_wb.reg_write),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.stall    (stall)
	);

	// execute
	function automatic logic [`MIPS_XLEN-1:0] fwd_mux(input mips_pkg::fwd_sel_e sel,
		input logic [`MIPS_XLEN-1:0] reg_val);
		case (sel)
			mips_pkg::FWD_MEM: return ex_mem.result;
			mips_pkg::FWD_WB:  return wb_data;
			default:           return reg_val;
		endcase
	endfunction

	always_comb begin
		op_a     = fwd_mux(fwd_a, id_ex.rs_data);
		op_b_reg = fwd_mux(fwd_b, id_ex.rt_data);
		alu_b    = id_ex.use_imm ? id_ex.imm : op_b_reg;
	end

	mips_alu u_alu (
		.op     (id_ex.alu_op),
		.a      (op_a),
		.b      (alu_b),
		.result (alu_result)
	);

	always_comb begin
		ex_mem_d.mem_read   = id_ex.mem_read;
		ex_mem_d.mem_write  = id_ex.mem_write;
		ex_mem_d.reg_write  = id_ex.reg_write;
		ex_mem_d.dest       = id_ex.dest;
		ex_mem_d.result     = alu_result;
		ex_mem_d.store_data = op_b_reg; // sw data needs forwarding too
	end

	always_ff @(posedge clk) begin
		if (reset)
			ex_mem <= '0;
		else
			ex_mem <= ex_mem_d;
	end

	// memory
	mips_dmem u_dmem (
		.clk   (clk),
		.req   (ex_mem),
		.rdata (mem_rdata),
		.store (store)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb.reg_write  <= 1'b0;
			mem_wb.mem_to_reg <= 1'b0;
		end else begin
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_read; // only lw returns memory data
		end
		mem_wb.dest      <= ex_mem.dest;
		mem_wb.result    <= ex_mem.result;
		mem_wb.load_data <= mem_rdata;
	end

	// writeback
	assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

	// strobe only for real register changes
	assign wb.valid = mem_wb.reg_write && (mem_wb.dest != '0);
	assign wb.idx   = mem_wb.dest;
	assign wb.data  = wb_data;

endmodule

`default_nettype wire

//--- design/mips_decode.sv
`default_nettype none

`include "mips_defines.svh"

module mips_decode (
	input  wire [`MIPS_XLEN-1:0] instr,
	output mips_pkg::id_ex_t     ctrl     // rs_data/rt_data filled by the core
);

	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e  funct;

	assign opcode = mips_pkg::opcode_e'(instr[31:26]);
	assign funct  = mips_pkg::funct_e'(instr[5:0]);

	always_comb begin
		ctrl = '0; // unknown opcode falls out as a bubble

		// fields common to every format
		ctrl.rs  = instr[25:21];
		ctrl.rt  = instr[20:16];
		ctrl.imm = {{(`MIPS_XLEN-`MIPS_IMM_W){instr[`MIPS_IMM_W-1]}},
			instr[`MIPS_IMM_W-1:0]};
		ctrl.dest = instr[20:16]; // I-type writes rt

		case (opcode)
			mips_pkg::OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest      = instr[15:11]; // rd
				case (funct)
					mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: ctrl.alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
					default:          ctrl.alu_op = mips_pkg::ALU_AND; // odd funct codes
				endcase
			end
			mips_pkg::OP_ADDI: begin
				ctrl.alu_op    = mips_pkg::ALU_ADD;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			mips_pkg::OP_LW: begin
				ctrl.alu_op    = mips_pkg::ALU_ADD; // base + offset
				ctrl.use_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			mips_pkg::OP_SW: begin
				ctrl.alu_op    = mips_pkg::ALU_ADD;
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1; // rt carries the store data
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- design/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// data path and byte address width
`define MIPS_XLEN 32

// register index width, 32 architectural registers
`define MIPS_REG_AW 5

// immediate field of I-type instructions
`define MIPS_IMM_W 16

// pc advance per instruction, in bytes
`define MIPS_PC_STEP 4

// data memory geometry
`define MIPS_DMEM_WORDS 128
`define MIPS_DMEM_AW 7 // word index, byte address bits 8:2

`endif

//--- design/mips_dmem.sv
`default_nettype none

`include "mips_defines.svh"

module mips_dmem (
	input  wire                   clk,
	input  mips_pkg::ex_mem_t     req,
	output logic [`MIPS_XLEN-1:0] rdata,
	output mips_pkg::store_t      store
);

	logic [`MIPS_XLEN-1:0]    mem [0:`MIPS_DMEM_WORDS-1] = '{default: '0};
	logic [`MIPS_DMEM_AW-1:0] idx;

	assign idx = req.result[`MIPS_DMEM_AW+1:2]; // word index, byte offset dropped

	always_ff @(posedge clk) begin
		if (req.mem_write)
			mem[idx] <= req.store_data;
	end

	// write-through read
	assign rdata = req.mem_write ? req.store_data : mem[idx];

	// observation strobe, one per sw
	assign store.valid = req.mem_write;
	assign store.idx   = idx;
	assign store.data  = req.store_data;

endmodule

`default_nettype wire

//--- design/mips_hazard.sv
`default_nettype none

`include "mips_defines.svh"

module mips_hazard (
	input  wire [`MIPS_REG_AW-1:0] id_rs,    // decode stage sources
	input  wire [`MIPS_REG_AW-1:0] id_rt,
	input  mips_pkg::id_ex_t       ex,
	input  mips_pkg::ex_mem_t      mem,
	input  wire [`MIPS_REG_AW-1:0] wb_dest,
	input  wire                    wb_write,
	output mips_pkg::fwd_sel_e     fwd_a,
	output mips_pkg::fwd_sel_e     fwd_b,
	output logic                   stall
);

	// youngest producer wins, r0 is never forwarded
	function automatic mips_pkg::fwd_sel_e pick(input logic [`MIPS_REG_AW-1:0] idx);
		if (idx == '0)
			return mips_pkg::FWD_REG;
		else if (mem.reg_write && (mem.dest == idx))
			return mips_pkg::FWD_MEM;
		else if (wb_write && (wb_dest == idx))
			return mips_pkg::FWD_WB;
		else
			return mips_pkg::FWD_REG;
	endfunction

	always_comb begin
		fwd_a = pick(ex.rs);
		fwd_b = pick(ex.rt); // also covers sw store data
	end

	// load data only exists after the memory stage, so a consumer
	// right behind a lw waits one cycle and then takes it from wb
	always_comb begin
		stall = ex.mem_read && ((ex.dest == id_rs) || (ex.dest == id_rt));
	end

endmodule

`default_nettype wire

//--- design/mips_pkg.sv
`default_nettype none

`include "mips_defines.svh"

package mips_pkg;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI  = 6'd8,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43
	} opcode_e;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADD = 6'd32,
		FN_SUB = 6'd34,
		FN_AND = 6'd36,
		FN_OR  = 6'd37,
		FN_XOR = 6'd38,
		FN_NOR = 6'd39,
		FN_SLT = 6'd42
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT
	} alu_op_e;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		FWD_REG, // value read in decode
		FWD_MEM, // alu result sitting in ex_mem
		FWD_WB   // final writeback data
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e                 alu_op;
		logic                    use_imm;   // b operand is the immediate
		logic                    mem_read;
		logic                    mem_write;
		logic                    reg_write;
		logic [`MIPS_REG_AW-1:0] dest;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [`MIPS_XLEN-1:0]   rs_data;
		logic [`MIPS_XLEN-1:0]   rt_data;
		logic [`MIPS_XLEN-1:0]   imm;       // already sign extended
	} id_ex_t;

	typedef struct packed {
		logic                    mem_read;
		logic                    mem_write;
		logic                    reg_write;
		logic [`MIPS_REG_AW-1:0] dest;
		logic [`MIPS_XLEN-1:0]   result;     // alu out, also the memory address
		logic [`MIPS_XLEN-1:0]   store_data;
	} ex_mem_t;

	typedef struct packed {
		logic                    reg_write;
		logic                    mem_to_reg;
		logic [`MIPS_REG_AW-1:0] dest;
		logic [`MIPS_XLEN-1:0]   result;
		logic [`MIPS_XLEN-1:0]   load_data;
	} mem_wb_t;

	typedef struct packed {
		logic                    valid;
		logic [`MIPS_REG_AW-1:0] idx;
		logic [`MIPS_XLEN-1:0]   data;
	} wb_t;

	typedef struct packed {
		logic                     valid;
		logic [`MIPS_DMEM_AW-1:0] idx;
		logic [`MIPS_XLEN-1:0]    data;
	} store_t;

endpackage

`default_nettype wire

//--- design/mips_regfile.sv
`default_nettype none

`include "mips_defines.svh"

module mips_regfile (
	input  wire                     clk,
	input  wire [`MIPS_REG_AW-1:0]  rs_idx,
	input  wire [`MIPS_REG_AW-1:0]  rt_idx,
	input  mips_pkg::wb_t           wr,      // valid never set for r0
	output logic [`MIPS_XLEN-1:0]   rs_data,
	output logic [`MIPS_XLEN-1:0]   rt_data
);

	// r0 has no storage
	logic [`MIPS_XLEN-1:0] regs [1:31] = '{default: '0};

	// one read port, with bypass of the write in flight
	function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [`MIPS_REG_AW-1:0] idx);
		if (idx == '0)
			return '0; // hard-wired zero
		else if (wr.valid && (wr.idx == idx))
			return wr.data; // same-cycle write wins
		else
			return regs[idx];
	endfunction

	always_comb begin
		rs_data = read_port(rs_idx);
		rt_data = read_port(rt_idx);
	end

	always_ff @(posedge clk) begin
		if (wr.valid)
			regs[wr.idx] <= wr.data;
	end

endmodule

`default_nettype wire

//--- dv/mips_tb_model.svh
`ifndef MIPS_TB_MODEL_SVH
`define MIPS_TB_MODEL_SVH

// architectural state, kept across tests like the DUT's regfile and dmem
logic [`MIPS_XLEN-1:0] mregs [0:31] = '{default: '0};
logic [`MIPS_XLEN-1:0] mmem [0:`MIPS_DMEM_WORDS-1] = '{default: '0};

// R-type, assembly order rd, rs, rt
function automatic logic [31:0] encode_r(input mips_pkg::funct_e fn, input int rd,
	input int rs, input int rt);
	return {mips_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

// I-type, assembly order rt, rs, imm
function automatic logic [31:0] encode_i(input mips_pkg::opcode_e op, input int rt,
	input int rs, input int imm);
	return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic void model_write(input logic [4:0] dest, input logic [31:0] val);
	mips_pkg::wb_t w;
	if (dest != 5'd0) begin // r0 is never written
		mregs[dest] = val;
		w = '{valid: 1'b1, idx: dest, data: val};
		exp_wb.push_back(w);
	end
endfunction

// reference model, runs the whole program in order
function automatic void run_model();
	logic [31:0]      instr;
	logic [31:0]      a;
	logic [31:0]      b;
	logic [31:0]      simm;
	logic [31:0]      ea;
	logic [31:0]      res;
	mips_pkg::store_t s;
	foreach (prog[i]) begin
		instr = prog[i];
		a     = mregs[instr[25:21]];
		b     = mregs[instr[20:16]];
		simm  = {{16{instr[15]}}, instr[15:0]};
		ea    = a + simm; // addi result or memory byte address
		case (mips_pkg::opcode_e'(instr[31:26]))
			mips_pkg::OP_RTYPE: begin
				case (mips_pkg::funct_e'(instr[5:0]))
					mips_pkg::FN_ADD: res = a + b;
					mips_pkg::FN_SUB: res = a - b;
					mips_pkg::FN_OR:  res = a | b;
					mips_pkg::FN_XOR: res = a ^ b;
					mips_pkg::FN_NOR: res = ~(a | b);
					mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:          res = a & b; // and, plus unknown codes
				endcase
				model_write(instr[15:11], res); // the all-zero nop lands on r0
			end
			mips_pkg::OP_ADDI: model_write(instr[20:16], ea);
			mips_pkg::OP_LW:   model_write(instr[20:16], mmem[ea[`MIPS_DMEM_AW+1:2]]);
			mips_pkg::OP_SW: begin
				mmem[ea[`MIPS_DMEM_AW+1:2]] = b;
				s = '{valid: 1'b1, idx: ea[`MIPS_DMEM_AW+1:2], data: b};
				exp_st.push_back(s);
			end
			default: ;
		endcase
	end
endfunction

function automatic void build_reset();
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 1, 0, 'h55));
	prog.push_back(encode_i(mips_pkg::OP_SW, 1, 0, 12)); // word 3
endfunction

function automatic void build_alu();
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 1, 0, -5));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 2, 0, 100));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 3, 0, -32768));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 4, 0, 1));
	repeat (31)
		prog.push_back(encode_r(mips_pkg::FN_ADD, 4, 4, 4)); // doubles up to 0x80000000
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 5, 0, -1));
	prog.push_back(encode_r(mips_pkg::FN_ADD, 6, 4, 5)); // 0x7fffffff
	prog.push_back(encode_r(mips_pkg::FN_ADD, 7, 1, 2));
	prog.push_back(encode_r(mips_pkg::FN_SUB, 8, 1, 2));
	prog.push_back(encode_r(mips_pkg::FN_AND, 9, 1, 3));
	prog.push_back(encode_r(mips_pkg::FN_OR, 10, 2, 3));
	prog.push_back(encode_r(mips_pkg::FN_XOR, 11, 1, 2));
	prog.push_back(encode_r(mips_pkg::FN_NOR, 12, 1, 2));
	prog.push_back(encode_r(mips_pkg::FN_SLT, 13, 1, 2));
	prog.push_back(encode_r(mips_pkg::FN_SLT, 14, 2, 1));
	prog.push_back(encode_r(mips_pkg::FN_SLT, 15, 4, 6)); // min - max overflows
	prog.push_back(encode_r(mips_pkg::FN_SLT, 16, 6, 4)); // and the other way round
	prog.push_back(encode_r(mips_pkg::FN_SLT, 17, 6, 5));
	prog.push_back(encode_r(mips_pkg::FN_SUB, 18, 4, 6));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 19, 6, -32768));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 20, 3, -1));
endfunction

// back-to-back chains, comments give the source of a and b
function automatic void build_fwd();
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 1, 0, 7));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 2, 0, 3));
	prog.push_back(encode_r(mips_pkg::FN_ADD, 3, 1, 2)); // wb, mem
	prog.push_back(encode_r(mips_pkg::FN_SUB, 4, 2, 3)); // wb, mem
	prog.push_back(encode_r(mips_pkg::FN_XOR, 5, 4, 3)); // mem, wb
	prog.push_back(encode_r(mips_pkg::FN_OR, 6, 5, 5));  // mem, mem
	prog.push_back(encode_r(mips_pkg::FN_AND, 7, 6, 5)); // mem, wb
	prog.push_back(encode_r(mips_pkg::FN_NOR, 8, 7, 7));
	prog.push_back(encode_r(mips_pkg::FN_SLT, 9, 8, 7));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 10, 9, -9));
	prog.push_back(encode_r(mips_pkg::FN_ADD, 11, 10, 10));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 12, 0, 9));
	prog.push_back(32'd0);
	prog.push_back(32'd0);
	prog.push_back(encode_r(mips_pkg::FN_ADD, 13, 12, 12)); // regfile bypass
	prog.push_back(encode_r(mips_pkg::FN_SUB, 14, 13, 12));
endfunction

function automatic void build_mem();
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 1, 0, 'h104)); // word 65
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 2, 0, -1234));
	prog.push_back(encode_i(mips_pkg::OP_SW, 2, 1, 0));  // data from mem, base from wb
	prog.push_back(encode_i(mips_pkg::OP_LW, 3, 1, 0));  // same word straight back
	prog.push_back(encode_r(mips_pkg::FN_ADD, 4, 3, 3)); // load-use stall
	prog.push_back(encode_i(mips_pkg::OP_SW, 4, 1, 8));  // word 67
	prog.push_back(encode_i(mips_pkg::OP_LW, 5, 1, 8));
	prog.push_back(encode_i(mips_pkg::OP_SW, 5, 1, -4)); // stall on store data, word 64
	prog.push_back(encode_i(mips_pkg::OP_LW, 6, 1, -4));
	prog.push_back(encode_r(mips_pkg::FN_ADD, 7, 6, 1));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 8, 0, 'h7ff0));
	prog.push_back(encode_i(mips_pkg::OP_SW, 7, 8, 'h20)); // 0x8010 wraps to word 4
	prog.push_back(encode_i(mips_pkg::OP_LW, 9, 0, 'h10));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 10, 9, 1));
endfunction

function automatic void build_zero();
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 0, 0, 5));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 1, 0, 11));
	prog.push_back(encode_r(mips_pkg::FN_ADD, 0, 1, 1));
	prog.push_back(encode_i(mips_pkg::OP_LW, 0, 0, 'h104));
	prog.push_back(encode_r(mips_pkg::FN_ADD, 2, 0, 0)); // must read zero
	prog.push_back(encode_r(mips_pkg::FN_OR, 3, 0, 1));
	prog.push_back(encode_r(mips_pkg::FN_SUB, 0, 1, 0));
	prog.push_back(encode_i(mips_pkg::OP_ADDI, 4, 0, -1));
endfunction

function automatic void build_random(input int len);
	logic [31:0]       r;
	int                kind;
	mips_pkg::funct_e  fn;
	mips_pkg::opcode_e op;
	for (int i = 0; i < len; i++) begin
		r    = $random(seed);
		kind = $unsigned($random(seed)) % 10;
		fn   = mips_pkg::FN_ADD;
		op   = mips_pkg::OP_ADDI;
		case (kind)
			1: fn = mips_pkg::FN_SUB;
			2: fn = mips_pkg::FN_AND;
			3: fn = mips_pkg::FN_OR;
			4: fn = mips_pkg::FN_XOR;
			5: fn = mips_pkg::FN_NOR;
			6: fn = mips_pkg::FN_SLT;
			8: op = mips_pkg::OP_LW;
			9: op = mips_pkg::OP_SW;
			default: ;
		endcase
		// r0..r15 only, keeps hazards dense
		if (kind < 7)
			prog.push_back(encode_r(fn, int'(r[11:8]), int'(r[3:0]), int'(r[7:4])));
		else
			prog.push_back(encode_i(op, int'(r[7:4]), int'(r[3:0]), int'(r[27:12])));
	end
endfunction

`endif

//--- dv/mips_tb.sv
`default_nettype none

`include "mips_defines.svh"

module mips_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES  = 16;
	localparam int DRAIN_CYCLES  = 50;
	localparam int SETTLE_CYCLES = 8;   // quiet tail, stray strobes show up here
	localparam int RANDOM_LEN    = 300;

	logic                  clk;
	logic                  reset;
	logic [`MIPS_XLEN-1:0] imem_addr;
	logic [`MIPS_XLEN-1:0] imem_data;
	mips_pkg::wb_t         wb;
	mips_pkg::store_t      store;

	logic [`MIPS_XLEN-1:0] prog [$];    // program of the running test
	mips_pkg::wb_t         exp_wb [$];
	mips_pkg::store_t      exp_st [$];
	string                 test_name;
	integer                seed;
	int                    cycles = 0;
	int                    cycle_limit = 10; // slack before the first test adds its budget

	`include "mips_tb_model.svh"

	mips_core u_mips_core (
		.clk       (clk),
		.reset     (reset),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb        (wb),
		.store     (store)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// past the end of the program reads as nop
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		int idx;
		idx = int'(addr[31:2]);
		if (idx < prog.size())
			return prog[idx];
		else
			return '0;
	endfunction

	initial begin
		forever begin
			@(posedge clk);
			#2;
			imem_data = fetch_word(imem_addr);
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_wb(input mips_pkg::wb_t exp, input mips_pkg::wb_t act);
		if (act !== exp)
			abort_run($sformatf("** Error %s: writeback expected r%0d = %h, actual r%0d = %h",
				test_name, exp.idx, exp.data, act.idx, act.data));
	endtask

	task automatic check_store(input mips_pkg::store_t exp, input mips_pkg::store_t act);
		if (act !== exp)
			abort_run($sformatf("** Error %s: store expected [%0d] = %h, actual [%0d] = %h",
				test_name, exp.idx, exp.data, act.idx, act.data));
	endtask

	// strobes sampled mid-cycle, each one pops its queue
	initial begin : compare
		mips_pkg::wb_t    e_wb;
		mips_pkg::store_t e_st;
		forever begin
			@(negedge clk);
			if (wb.valid === 1'b1) begin
				if (exp_wb.size() == 0)
					abort_run($sformatf("%s: writeback to r%0d with no result expected",
						test_name, wb.idx));
				e_wb = exp_wb.pop_front();
				check_wb(e_wb, wb);
			end
			if (store.valid === 1'b1) begin
				if (exp_st.size() == 0)
					abort_run($sformatf("%s: store to word %0d with no store expected",
						test_name, store.idx));
				e_st = exp_st.pop_front();
				check_store(e_st, store);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit)
			abort_run($sformatf("%s: timed out after %0d cycles, %0d writebacks and %0d stores %s",
				test_name, cycles, exp_wb.size(), exp_st.size(), "never arrived"));
	end

	task automatic expect_idle(input string when, input bit addr_zero);
		if (addr_zero && imem_addr !== '0)
			abort_run($sformatf("%s: fetch address is %h %s instead of zero",
				test_name, imem_addr, when));
		if (wb.valid !== 1'b0 || store.valid !== 1'b0)
			abort_run($sformatf("%s: a result strobe is active %s", test_name, when));
	endtask

	task automatic hold_reset();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			if (i > 0)
				expect_idle("during reset", 1'b1); // first edge not seen yet at i == 0
			@(posedge clk);
		end
		#2;
		reset = 1'b0;
		// first instruction cannot have reached memory or writeback yet
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			expect_idle("right after reset", i == 0);
		end
	endtask

	task automatic run_test(input string name, input int which);
		@(posedge clk);
		#2;
		reset = 1'b1; // before the new program shows up on the fetch port
		test_name = name;
		prog.delete();
		case (which)
			0: build_reset();
			1: build_alu();
			2: build_fwd();
			3: build_mem();
			4: build_zero();
			default: build_random(RANDOM_LEN);
		endcase
		run_model();
		cycle_limit += 2 * prog.size() + DRAIN_CYCLES + RESET_CYCLES + SETTLE_CYCLES;
		hold_reset();
		while (exp_wb.size() != 0 || exp_st.size() != 0)
			@(posedge clk);
		repeat (SETTLE_CYCLES) @(posedge clk);
		$display("%s: %0d instructions checked", name, prog.size());
	endtask

	initial begin
		reset     = 1'b1;
		imem_data = '0;
		seed      = 32'hc28b;
		run_test("reset", 0);
		run_test("alu", 1);
		run_test("forwarding", 2);
		run_test("load_store", 3);
		run_test("reg_zero", 4);
		run_test("random", 5);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
+incdir+dv
design/mips_pkg.sv
design/mips_regfile.sv
design/mips_decode.sv
design/mips_alu.sv
design/mips_hazard.sv
design/mips_dmem.sv
design/mips_core.sv
dv/mips_tb.sv
